// ==== src.f ====
x86_dec_pkg.sv
fetch_window_rx.sv
hs_pipe_reg.sv
modrm_decode.sv
decoded_tx.sv
decode_top.sv
tb_clock_gen.sv
tb_decode_sva.sv
tb_decode.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_decode -o tb_decode_sim

# The simulator exits non-zero on a failure, the search below decides the result
out=$(./obj_dir/tb_decode_sim || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors"

// ==== tb_decode.sv ====
module tb_decode;

    import x86_dec_pkg::*;

    localparam int N_WIN   = 300;
    localparam int T_LIMIT = 200;                  // Cycles per wait loop

    logic        clk;
    logic        arst_n;
    logic        in_req;
    logic        in_ack;
    instr_win_t  in_win;
    logic        out_ack;
    logic        out_req;
    modrm_ctrl_t out_ctrl;

    logic [31:0] lfsr_q = 32'h761c;
    instr_win_t  win_arr [N_WIN];
    int          ack_dly [N_WIN];
    modrm_ctrl_t exp_q [$];                        // Expected words in input order

    tb_clock_gen clk_gen_i (.clk(clk), .arst_n(arst_n));

    decode_top dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_win   (in_win),
        .out_ack  (out_ack),
        .out_req  (out_req),
        .out_ctrl (out_ctrl)
    );

    bind decode_top tb_decode_sva sva_i (
        .clk(clk), .arst_n(arst_n), .in_req(in_req), .in_ack(in_ack),
        .out_req(out_req), .out_ack(out_ack), .out_ctrl(out_ctrl)
    );

    // **************************************************************************
    // Random source and reference model
    // **************************************************************************

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic modrm_ctrl_t model_ctrl(instr_win_t w);
        modrm_ctrl_t c;
        logic [2:0]  pos;
        logic [7:0]  m;
        logic [7:0]  s;
        logic [3:0]  dbytes;
        c   = '0;
        pos = w.prefix_cnt + 3'd1 + 3'(w.two_byte_op);   // Behind prefixes and opcode
        m   = w.bytes[pos];
        s   = w.bytes[pos + 3'd1];
        c.mod      = m[7:6];
        c.reg_op   = m[5:3];
        c.rm       = m[2:0];
        c.reg_form = (m[7:6] == 2'b11);
        c.has_sib  = (m[7:6] != 2'b11) && (m[2:0] == 3'd4);
        if (c.has_sib) begin
            c.scale = s[7:6];
            c.index = s[5:3];
            c.base  = s[2:0];
        end
        if (m[7:6] == 2'b01)
            c.disp = DISP_8;
        else if (m[7:6] == 2'b10 ||
                 (m[7:6] == 2'b00 && (m[2:0] == 3'd5 || (c.has_sib && s[2:0] == 3'd5))))
            c.disp = DISP_32;
        else
            c.disp = DISP_NONE;
        dbytes     = (c.disp == DISP_8) ? 4'd1 : (c.disp == DISP_32) ? 4'd4 : 4'd0;
        c.insn_len = 4'(pos) + 4'd1 + 4'(c.has_sib) + dbytes;
        return c;
    endfunction

    task automatic build_stimulus();
        instr_win_t w;
        logic [2:0] pos;
        logic [7:0] r;
        for (int i = 0; i < N_WIN; i++) begin
            w.bytes = {take_bits(32), take_bits(32)};
            if (i < 10) begin                      // Every prefix count, with and without 0F
                w.prefix_cnt  = 3'(i / 2);
                w.two_byte_op = 1'(i % 2);
            end else begin
                w.prefix_cnt  = 3'(take_bits(3) % (MAX_PREFIX + 1));
                w.two_byte_op = 1'(take_bits(1));
            end
            pos = w.prefix_cnt + 3'd1 + 3'(w.two_byte_op);
            r   = 8'(take_bits(8));
            if (i >= 10 && i < 90) begin
                case (i % 8)
                    0: w.bytes[pos] = {2'b11, r[5:0]};
                    1: w.bytes[pos] = {2'b01, r[5:0]};
                    2: w.bytes[pos] = {2'b10, r[5:0]};
                    3: w.bytes[pos] = {2'b00, r[5:3], 3'd5};
                    4, 5: begin                    // SIB without base, mod 0 and mod 1
                        w.bytes[pos] = {1'b0, 1'(i % 2), r[5:3], 3'd4};
                        w.bytes[pos + 3'd1][2:0] = 3'd5;
                    end
                    6: w.bytes[pos] = {2'b00, r[5:3], 3'd4};
                    default: w.bytes[pos] = {2'b00, r[5:0]};
                endcase
            end
            win_arr[i] = w;
            ack_dly[i] = int'(take_bits(3));
        end
    endtask

    // **************************************************************************
    // Checks and waits
    // **************************************************************************
    task automatic fail_run();
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic logic field_differs(string name, logic [31:0] exp, logic [31:0] act);
        if (act === exp)
            return 1'b0;
        $display("ERROR out_ctrl.%s exp %h act %h", name, exp, act);
        return 1'b1;
    endfunction

    task automatic check_ctrl(modrm_ctrl_t exp, modrm_ctrl_t act);
        logic bad;
        bad = 1'b0;
        bad |= field_differs("mod", 32'(exp.mod), 32'(act.mod));
        bad |= field_differs("reg_op", 32'(exp.reg_op), 32'(act.reg_op));
        bad |= field_differs("rm", 32'(exp.rm), 32'(act.rm));
        bad |= field_differs("reg_form", 32'(exp.reg_form), 32'(act.reg_form));
        bad |= field_differs("has_sib", 32'(exp.has_sib), 32'(act.has_sib));
        bad |= field_differs("scale", 32'(exp.scale), 32'(act.scale));
        bad |= field_differs("index", 32'(exp.index), 32'(act.index));
        bad |= field_differs("base", 32'(exp.base), 32'(act.base));
        bad |= field_differs("disp", 32'(exp.disp), 32'(act.disp));
        bad |= field_differs("insn_len", 32'(exp.insn_len), 32'(act.insn_len));
        if (bad)
            fail_run();
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERROR %s exp %h act %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic wait_in_ack(logic level);
        int cnt;
        cnt = 0;
        while (in_ack !== level) begin
            @(negedge clk);
            cnt++;
            if (cnt > T_LIMIT) begin
                $display("Timeout: in_ack did not go to %0d", level);
                fail_run();
            end
        end
    endtask

    task automatic wait_out_req(logic level);
        int cnt;
        cnt = 0;
        while (out_req !== level) begin
            @(negedge clk);
            cnt++;
            if (cnt > T_LIMIT) begin
                $display("Timeout: out_req did not go to %0d", level);
                fail_run();
            end
        end
    endtask

    // **************************************************************************
    // Main sequence
    // **************************************************************************
    initial begin
        int   cnt;
        logic prod_done;
        in_req    = 1'b0;
        in_win    = '0;
        out_ack   = 1'b0;
        cnt       = 0;
        prod_done = 1'b0;
        build_stimulus();

        @(negedge clk);
        while (!arst_n) begin                      // Handshake outputs quiet in reset
            check_bit("in_ack", 1'b0, in_ack);
            check_bit("out_req", 1'b0, out_req);
            @(negedge clk);
            cnt++;
            if (cnt > T_LIMIT) begin
                $display("Timeout: reset was never released");
                fail_run();
            end
        end
        check_bit("in_ack", 1'b0, in_ack);
        check_bit("out_req", 1'b0, out_req);

        fork
            begin                                  // Producer
                for (int i = 0; i < N_WIN; i++) begin
                    in_win = win_arr[i];
                    in_req = 1'b1;
                    exp_q.push_back(model_ctrl(win_arr[i]));
                    wait_in_ack(1'b1);
                    in_req = 1'b0;
                    wait_in_ack(1'b0);
                end
                prod_done = 1'b1;
            end
            begin                                  // Consumer with random ack delay
                int k;
                int idle;
                k    = 0;
                idle = 0;
                // Runs until the producer is done and the output stays quiet
                while (!prod_done || idle < T_LIMIT) begin
                    @(negedge clk);
                    if (out_req === 1'b1) begin
                        if (exp_q.size() == 0) begin
                            $display("Control word arrived with no window outstanding");
                            fail_run();
                        end
                        check_ctrl(exp_q.pop_front(), out_ctrl);
                        repeat (ack_dly[k]) @(negedge clk);
                        out_ack = 1'b1;
                        wait_out_req(1'b0);
                        out_ack = 1'b0;
                        k++;
                        idle = 0;
                    end else begin
                        idle++;
                    end
                end
            end
        join

        if (exp_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("%0d expected control words never arrived", exp_q.size());
            fail_run();
        end
    end

endmodule

// ==== tb_decode_sva.sv ====
module tb_decode_sva (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     in_req,
    input logic                     in_ack,
    input logic                     out_req,
    input logic                     out_ack,
    input x86_dec_pkg::modrm_ctrl_t out_ctrl
);

    // in_ack may only rise on an edge where the request was seen high
    ack_follows_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req)
    ) else $error("in_ack rose without in_req");

    // Word held while the sender waits for the acknowledge
    ctrl_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_req && !out_ack) |=> $stable(out_ctrl)
    ) else $error("out_ctrl changed while out_req was waiting");

    req_held_until_ack: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(out_req) |-> $past(out_ack)
    ) else $error("out_req fell before out_ack was seen");

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int PERIOD = 8;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Four rising edges in reset, released on the following falling edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== decode_top.sv ====
module decode_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_req,
    output logic                     in_ack,
    input  x86_dec_pkg::instr_win_t  in_win,
    input  logic                     out_ack,
    output logic                     out_req,
    output x86_dec_pkg::modrm_ctrl_t out_ctrl
);

    import x86_dec_pkg::*;

    logic        rx_valid;
    logic        rx_ready;
    instr_win_t  rx_data;

    logic        dec_in_valid;
    logic        dec_in_ready;
    instr_win_t  dec_in_win;

    logic        dec_out_valid;
    logic        dec_out_ready;
    modrm_ctrl_t dec_out_ctrl;

    logic        tx_valid;
    logic        tx_ready;
    modrm_ctrl_t tx_data;

    // **************************************************************************
    // Input side
    // **************************************************************************
    fetch_window_rx rx_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_win    (in_win),
        .win_valid (rx_valid),
        .win_ready (rx_ready),
        .win_data  (rx_data)
    );

    hs_pipe_reg #(.T(instr_win_t)) win_slot_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (rx_valid),
        .in_ready  (rx_ready),
        .in_data   (rx_data),
        .out_valid (dec_in_valid),
        .out_ready (dec_in_ready),
        .out_data  (dec_in_win)
    );

    // **************************************************************************
    // Decode
    // **************************************************************************
    modrm_decode decode_i (
        .in_valid  (dec_in_valid),
        .in_ready  (dec_in_ready),
        .in_win    (dec_in_win),
        .out_valid (dec_out_valid),
        .out_ready (dec_out_ready),
        .out_ctrl  (dec_out_ctrl)
    );

    hs_pipe_reg #(.T(modrm_ctrl_t)) ctrl_slot_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (dec_out_valid),
        .in_ready  (dec_out_ready),
        .in_data   (dec_out_ctrl),
        .out_valid (tx_valid),
        .out_ready (tx_ready),
        .out_data  (tx_data)
    );

    // **************************************************************************
    // Output side
    // **************************************************************************
    decoded_tx tx_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl_valid (tx_valid),
        .ctrl_ready (tx_ready),
        .ctrl_data  (tx_data),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_ctrl   (out_ctrl)
    );

endmodule

// ==== decoded_tx.sv ====
module decoded_tx (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     ctrl_valid,
    output logic                     ctrl_ready,
    input  x86_dec_pkg::modrm_ctrl_t ctrl_data,
    output logic                     out_req,
    input  logic                     out_ack,
    output x86_dec_pkg::modrm_ctrl_t out_ctrl
);

    import x86_dec_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,         // out_req high, word held
        TX_ACK_LOW      // Wait for out_ack to drop
    } tx_state_t;

    tx_state_t   state;
    modrm_ctrl_t hold_q;

    assign ctrl_ready = (state == TX_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (ctrl_valid)
                        state <= TX_REQ;
                end
                TX_REQ: begin
                    if (out_ack)
                        state <= TX_ACK_LOW;
                end
                TX_ACK_LOW: begin
                    if (!out_ack)
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_valid && ctrl_ready)
            hold_q <= ctrl_data;
    end

    assign out_req  = (state == TX_REQ);   // Registered, one cycle after the take
    assign out_ctrl = hold_q;

endmodule

// ==== modrm_decode.sv ====
module modrm_decode (
    input  logic                     in_valid,
    output logic                     in_ready,
    input  x86_dec_pkg::instr_win_t  in_win,
    output logic                     out_valid,
    input  logic                     out_ready,
    output x86_dec_pkg::modrm_ctrl_t out_ctrl
);

    import x86_dec_pkg::*;

    logic [IDX_W-1:0] modrm_idx;
    logic [IDX_W-1:0] sib_idx;
    logic [7:0]       modrm_byte;
    logic [7:0]       sib_byte;

    // Pure combinational stage, handshake passes straight through
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    // **************************************************************************
    // Byte selection
    // **************************************************************************
    always_comb begin
        modrm_idx  = IDX_W'(in_win.prefix_cnt) + IDX_W'(1) + IDX_W'(in_win.two_byte_op);
        sib_idx    = modrm_idx + IDX_W'(1);
        modrm_byte = in_win.bytes[modrm_idx];
        sib_byte   = in_win.bytes[sib_idx];
    end

    // **************************************************************************
    // Field decode
    // **************************************************************************
    always_comb begin
        out_ctrl = '0;

        out_ctrl.mod      = modrm_byte[7:6];
        out_ctrl.reg_op   = modrm_byte[5:3];
        out_ctrl.rm       = modrm_byte[2:0];
        out_ctrl.reg_form = (modrm_byte[7:6] == 2'd3);
        out_ctrl.has_sib  = !out_ctrl.reg_form && (modrm_byte[2:0] == 3'd4);

        if (out_ctrl.has_sib) begin
            out_ctrl.scale = sib_byte[7:6];
            out_ctrl.index = sib_byte[5:3];
            out_ctrl.base  = sib_byte[2:0];
        end

        case (out_ctrl.mod)
            2'd0: begin
                // Absolute disp32, or SIB with no base register
                if (out_ctrl.rm == 3'd5 || (out_ctrl.has_sib && out_ctrl.base == 3'd5))
                    out_ctrl.disp = DISP_32;
                else
                    out_ctrl.disp = DISP_NONE;
            end
            2'd1:    out_ctrl.disp = DISP_8;
            2'd2:    out_ctrl.disp = DISP_32;
            default: out_ctrl.disp = DISP_NONE;
        endcase

        out_ctrl.insn_len = 4'(modrm_idx) + 4'd1 + 4'(out_ctrl.has_sib) + 4'(out_ctrl.disp);
    end

endmodule

// ==== hs_pipe_reg.sv ====
module hs_pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic full;
    T     data_q;

    // Take a new item when empty or when the current one leaves this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            full <= 1'b0;
        else if (in_valid && in_ready)
            full <= 1'b1;
        else if (out_ready)
            full <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

// ==== fetch_window_rx.sv ====
module fetch_window_rx (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_req,
    output logic                    in_ack,
    input  x86_dec_pkg::instr_win_t in_win,
    output logic                    win_valid,
    input  logic                    win_ready,
    output x86_dec_pkg::instr_win_t win_data
);

    import x86_dec_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,        // Empty, in_ack low
        RX_HOLD,        // Window held for downstream
        RX_WAIT         // Empty, in_ack still high until in_req drops
    } rx_state_t;

    rx_state_t  state;
    instr_win_t hold_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= RX_IDLE;
            in_ack <= 1'b0;
        end else begin
            if (in_ack && !in_req)
                in_ack <= 1'b0;                    // Close the four-phase cycle

            case (state)
                RX_IDLE: begin
                    if (in_req) begin
                        state  <= RX_HOLD;
                        in_ack <= 1'b1;
                    end
                end
                RX_HOLD: begin
                    if (win_ready)
                        state <= (in_ack && in_req) ? RX_WAIT : RX_IDLE;
                end
                RX_WAIT: begin
                    if (!in_req)
                        state <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_IDLE && in_req)
            hold_q <= in_win;
    end

    assign win_valid = (state == RX_HOLD);
    assign win_data  = hold_q;

endmodule

// ==== x86_dec_pkg.sv ====
package x86_dec_pkg;

    // **************************************************************************
    // Window geometry
    // **************************************************************************
    localparam int WIN_BYTES  = 8;
    localparam int MAX_PREFIX = 4;
    localparam int IDX_W      = $clog2(WIN_BYTES);     // Byte index into the window

    // **************************************************************************
    // Types
    // **************************************************************************

    // Encoded value is the displacement size in bytes
    typedef enum logic [2:0] {
        DISP_NONE = 3'd0,
        DISP_8    = 3'd1,
        DISP_32   = 3'd4
    } disp_t;

    typedef struct packed {
        logic [WIN_BYTES-1:0][7:0] bytes;          // bytes[0] is the first byte
        logic [2:0]                prefix_cnt;     // 0 to MAX_PREFIX
        logic                      two_byte_op;    // 0F escape present
    } instr_win_t;

    // reg is a keyword, so the ModR/M reg field is reg_op
    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;
        logic [2:0] rm;
        logic       reg_form;                      // Operand is a register
        logic       has_sib;
        logic [1:0] scale;
        logic [2:0] index;
        logic [2:0] base;
        disp_t      disp;
        logic [3:0] insn_len;                      // Length through the displacement
    } modrm_ctrl_t;

endpackage
